//--- exec_unit.f
source/rv_isa_pkg.sv
source/alu_pkg.sv
source/instr_decoder.sv
source/ex_operand_reg.sv
source/alu.sv
source/branch_unit.sv
source/ex_result_reg.sv
source/exec_unit.sv
bench/exec_unit_properties.sv
bench/exec_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the execute stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f exec_unit.f --top-module exec_unit_tb -o exec_unit_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/exec_unit_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1

//--- bench/exec_unit_tb.sv
/* execute stage testbench: clock, reset, LFSR instruction stimulus,
   reference model with an expectation queue, output checks and watchdog */
`timescale 1ns/100ps
`default_nettype none

module exec_unit_tb import rv_isa_pkg::*;;

  localparam int XLEN       = 32;
  localparam int CLK_PERIOD = 40;
  localparam int N_STIM     = 3000;  // stimulus cycles after reset

  typedef struct packed {
    int          out_edge;  // edge count at which the result must be visible
    logic [4:0]  rd;
    logic        we;
    logic [31:0] data;
    logic        redir;
    logic [31:0] target;
  } exp_t;

  logic        i_clk, i_rst, i_valid;
  logic [31:0] i_instr, i_pc, i_rs1_data, i_rs2_data;
  logic        o_valid, o_rd_we, o_redirect;
  logic [4:0]  o_rd_addr;
  logic [31:0] o_rd_data, o_target;

  logic [31:0] lfsr = 32'h657b4a9b;
  int          edge_cnt = 0;
  int          mism_cnt = 0;
  int          other_cnt = 0;
  exp_t        exp_q[$];
  exp_t        head, s_exp;
  logic        s_valid;
  logic [31:0] s_instr, s_pc, s_rs1, s_rs2;

  exec_unit #(.XLEN(XLEN)) dut (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_valid), .i_instr(i_instr), .i_pc(i_pc),
    .i_rs1_data(i_rs1_data), .i_rs2_data(i_rs2_data), .o_valid(o_valid),
    .o_rd_addr(o_rd_addr), .o_rd_we(o_rd_we), .o_rd_data(o_rd_data),
    .o_redirect(o_redirect), .o_target(o_target)
  );

  bind exec_unit exec_unit_properties #(.XLEN(XLEN)) u_props (
    .i_clk(i_clk), .i_rst(i_rst), .o_valid(o_valid), .o_rd_we(o_rd_we),
    .o_redirect(o_redirect), .o_target(o_target)
  );

  // Galois LFSR with taps 32 22 2 1 stepped once per bit handed out
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // random instruction of a supported class or now and then an unknown opcode
  function automatic logic [31:0] make_instr();
    logic [31:0] ins;
    logic [3:0]  pick;
    pick = 4'(next_bits(4));
    ins  = next_bits(32);
    case (pick)
      4'd0, 4'd1, 4'd2, 4'd3, 4'd15: ins[6:0] = OP;
      4'd4, 4'd5, 4'd6:              ins[6:0] = OP_IMM;
      4'd7:                          ins[6:0] = LUI;
      4'd8:                          ins[6:0] = AUIPC;
      4'd9:                          ins[6:0] = JAL;
      4'd10:                         ins[6:0] = JALR;
      4'd11, 4'd12, 4'd13:           ins[6:0] = BRANCH;
      default: begin
        if (ins[6:0] inside {OP, OP_IMM, LUI, AUIPC, JAL, JALR, BRANCH}) begin
          ins[6:0] = 7'b0000011;  // load opcode which this stage does not handle
        end
      end
    endcase
    if (ins[6:0] == OP || (ins[6:0] == OP_IMM && ins[13:12] == 2'b01)) begin
      ins[31:25] = {1'b0, ins[30], 5'b0};  // legal funct7 for ALU ops and shifts
    end
    if (ins[6:0] == JALR) begin
      ins[14:12] = 3'b000;
    end
    if (ins[6:0] == BRANCH && ins[14:13] == 2'b01) begin
      ins[14] = 1'b1;  // steer the two reserved funct3 codes onto real branches
    end
    return ins;
  endfunction

  // reference model of one instruction from the ISA rules
  function automatic exp_t predict(input logic [31:0] ins, pc, rs1, rs2);
    exp_t        e;
    logic [31:0] imm_i, imm_u, imm_b, imm_j, opb;
    logic [2:0]  f3;
    logic        alt, taken;
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_u = {ins[31:12], 12'b0};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    f3    = ins[FUNCT3_LSB +: 3];
    alt   = ins[FUNCT7_B5];
    opb   = (ins[6:0] == OP) ? rs2 : imm_i;
    taken = 1'b0;
    e     = '0;
    e.rd  = ins[RD_LSB +: 5];
    case (ins[6:0])
      OP, OP_IMM: begin
        e.we = 1'b1;
        case (f3)
          3'b000: e.data = (ins[6:0] == OP && alt) ? rs1 - opb : rs1 + opb;
          3'b001: e.data = rs1 << opb[4:0];
          3'b010: e.data = ($signed(rs1) < $signed(opb)) ? 32'd1 : 32'd0;
          3'b011: e.data = (rs1 < opb) ? 32'd1 : 32'd0;
          3'b100: e.data = rs1 ^ opb;
          3'b101: begin
            if (alt) begin
              e.data = $signed(rs1) >>> opb[4:0];
            end else begin
              e.data = rs1 >> opb[4:0];
            end
          end
          3'b110:  e.data = rs1 | opb;
          default: e.data = rs1 & opb;
        endcase
      end
      LUI: begin
        e.we   = 1'b1;
        e.data = imm_u;
      end
      AUIPC: begin
        e.we   = 1'b1;
        e.data = pc + imm_u;
      end
      JAL: begin
        e.we     = 1'b1;
        e.data   = pc + 32'd4;
        e.redir  = 1'b1;
        e.target = pc + imm_j;
      end
      JALR: begin
        e.we     = 1'b1;
        e.data   = pc + 32'd4;
        e.redir  = 1'b1;
        e.target = (rs1 + imm_i) & 32'hFFFF_FFFE;
      end
      BRANCH: begin
        case (f3)
          BEQ:     taken = (rs1 == rs2);
          BNE:     taken = (rs1 != rs2);
          BLT:     taken = ($signed(rs1) < $signed(rs2));
          BGE:     taken = ($signed(rs1) >= $signed(rs2));
          BLTU:    taken = (rs1 < rs2);
          BGEU:    taken = (rs1 >= rs2);
          default: taken = 1'b0;
        endcase
        e.redir  = taken;
        e.target = pc + imm_b;
      end
      default: ;  // unknown opcodes leave everything clear
    endcase
    if (e.rd == 5'd0) begin
      e.we = 1'b0;
    end
    return e;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else begin
      mism_cnt++;
      $display("mismatch at %0d ns: %s got %h expected %h", $time, what, got, want);
    end
  endtask

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  always @(posedge i_clk) edge_cnt <= edge_cnt + 1;

  initial begin
    i_rst      = 1'b1;
    i_valid    = 1'b0;
    i_instr    = '0;
    i_pc       = '0;
    i_rs1_data = '0;
    i_rs2_data = '0;
    repeat (4) @(posedge i_clk);
    i_rst <= 1'b0;
    for (int n = 0; n < N_STIM; n++) begin
      @(posedge i_clk);
      s_valid = (next_bits(2) != 32'd0);  // about three in four cycles carry an instruction
      s_instr = make_instr();
      s_rs1   = next_bits(32);
      s_rs2   = (next_bits(3) == 32'd0) ? s_rs1 : next_bits(32);  // equal operands now and then
      s_pc    = next_bits(32) & 32'hFFFF_FFFC;
      i_valid    <= s_valid;
      i_instr    <= s_instr;
      i_pc       <= s_pc;
      i_rs1_data <= s_rs1;
      i_rs2_data <= s_rs2;
      if (s_valid) begin
        s_exp          = predict(s_instr, s_pc, s_rs1, s_rs2);
        s_exp.out_edge = edge_cnt + 3;  // sampled at the next edge and visible two edges later
        exp_q.push_back(s_exp);
      end
    end
    @(posedge i_clk);
    i_valid <= 1'b0;
    repeat (3) @(posedge i_clk);
    assert (exp_q.size() == 0) else begin
      other_cnt++;
      $display("%0d instructions never came out of the execute stage", exp_q.size());
    end
    $display("errors: %0d value mismatches, %0d other failures", mism_cnt, other_cnt);
    if (mism_cnt == 0 && other_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // outputs change on the rising edge and hold still at the falling edge
  always @(negedge i_clk) begin
    if (edge_cnt > 0) begin
      assert (o_valid === 1'b1 || (o_rd_we === 1'b0 && o_redirect === 1'b0)) else begin
        other_cnt++;
        $display("write enable or redirect high without o_valid at %0d ns", $time);
      end
      if (o_valid === 1'b1) begin
        assert (exp_q.size() > 0) else begin
          other_cnt++;
          $display("o_valid high at %0d ns with no instruction in flight", $time);
        end
        if (exp_q.size() > 0) begin
          head = exp_q.pop_front();
          check_value("output edge", edge_cnt, head.out_edge);
          check_value("rd_addr", 32'(o_rd_addr), 32'(head.rd));
          check_value("rd_we", 32'(o_rd_we), 32'(head.we));
          check_value("redirect", 32'(o_redirect), 32'(head.redir));
          if (head.we) begin
            check_value("rd_data", o_rd_data, head.data);
          end
          if (head.redir) begin
            check_value("target", o_target, head.target);
          end
        end
      end
    end
  end

  initial begin
    #((N_STIM + 20) * CLK_PERIOD);
    $display("timeout: the run did not finish in the expected number of cycles");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/exec_unit_properties.sv
/* concurrent checks on the execute stage outputs, bound into exec_unit */
`timescale 1ns/100ps
`default_nettype none

module exec_unit_properties #(
  parameter int XLEN = 32
) (
  input wire logic            i_clk,
  input wire logic            i_rst,
  input wire logic            o_valid,
  input wire logic            o_rd_we,
  input wire logic            o_redirect,
  input wire logic [XLEN-1:0] o_target
);

  we_needs_valid: assert property (@(posedge i_clk) disable iff (i_rst) o_rd_we |-> o_valid)
    else $error("register write enable is high while o_valid is low");

  redirect_needs_valid: assert property (
    @(posedge i_clk) disable iff (i_rst) o_redirect |-> o_valid)
    else $error("redirect is high while o_valid is low");

  // every target is halfword aligned at least, JALR clears bit 0 itself
  target_aligned: assert property (@(posedge i_clk) disable iff (i_rst) o_redirect |-> !o_target[0])
    else $error("redirect target has bit 0 set");

endmodule

`default_nettype wire

//--- source/exec_unit.sv
/* execute stage top level: decoder, operand register, ALU, branch unit
   and result register */
`timescale 1ns/100ps
`default_nettype none

module exec_unit import rv_isa_pkg::*, alu_pkg::*; #(
  parameter int XLEN = 32
) (
  input  wire logic               i_clk,
  input  wire logic               i_rst,
  input  wire logic               i_valid,
  input  wire logic [INSTR_W-1:0] i_instr,
  input  wire logic [XLEN-1:0]    i_pc,
  input  wire logic [XLEN-1:0]    i_rs1_data,
  input  wire logic [XLEN-1:0]    i_rs2_data,
  output logic                    o_valid,
  output logic      [4:0]         o_rd_addr,
  output logic                    o_rd_we,
  output logic      [XLEN-1:0]    o_rd_data,
  output logic                    o_redirect,
  output logic      [XLEN-1:0]    o_target
);

  // decode outputs, same cycle as the input
  alu_op_t         dec_alu_op;
  a_sel_t          dec_a_sel;
  b_sel_t          dec_b_sel;
  logic [XLEN-1:0] dec_imm;
  logic [4:0]      dec_rd_addr;
  logic            dec_rd_we, dec_is_branch, dec_is_jal, dec_is_jalr;
  logic [2:0]      dec_funct3;

  // first register stage
  logic            ex_valid;
  logic [XLEN-1:0] ex_a, ex_b, ex_pc, ex_rs1, ex_imm;
  alu_op_t         ex_alu_op;
  logic [4:0]      ex_rd_addr;
  logic            ex_rd_we, ex_is_branch, ex_is_jal, ex_is_jalr;
  logic [2:0]      ex_funct3;

  logic [XLEN-1:0] alu_result, br_target;
  logic            zflag, cflag, lflag, br_taken;

  instr_decoder #(.XLEN(XLEN)) u_decoder (
    .i_instr(i_instr), .o_alu_op(dec_alu_op), .o_a_sel(dec_a_sel), .o_b_sel(dec_b_sel),
    .o_imm(dec_imm), .o_rd_addr(dec_rd_addr), .o_rd_we(dec_rd_we),
    .o_is_branch(dec_is_branch), .o_is_jal(dec_is_jal), .o_is_jalr(dec_is_jalr),
    .o_funct3(dec_funct3)
  );

  ex_operand_reg #(.XLEN(XLEN)) u_operand_reg (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_valid), .i_pc(i_pc),
    .i_rs1_data(i_rs1_data), .i_rs2_data(i_rs2_data), .i_alu_op(dec_alu_op),
    .i_a_sel(dec_a_sel), .i_b_sel(dec_b_sel), .i_imm(dec_imm), .i_rd_addr(dec_rd_addr),
    .i_rd_we(dec_rd_we), .i_is_branch(dec_is_branch), .i_is_jal(dec_is_jal),
    .i_is_jalr(dec_is_jalr), .i_funct3(dec_funct3),
    .o_valid(ex_valid), .o_a(ex_a), .o_b(ex_b), .o_alu_op(ex_alu_op), .o_pc(ex_pc),
    .o_rs1(ex_rs1), .o_imm(ex_imm), .o_rd_addr(ex_rd_addr), .o_rd_we(ex_rd_we),
    .o_is_branch(ex_is_branch), .o_is_jal(ex_is_jal), .o_is_jalr(ex_is_jalr),
    .o_funct3(ex_funct3)
  );

  alu #(.XLEN(XLEN)) u_alu (
    .i_a(ex_a), .i_b(ex_b), .i_op(ex_alu_op), .o_result(alu_result),
    .o_zflag(zflag), .o_cflag(cflag), .o_lflag(lflag)
  );

  branch_unit #(.XLEN(XLEN)) u_branch (
    .i_is_branch(ex_is_branch), .i_is_jal(ex_is_jal), .i_is_jalr(ex_is_jalr),
    .i_funct3(br_funct3_t'(ex_funct3)), .i_zflag(zflag), .i_cflag(cflag), .i_lflag(lflag),
    .i_pc(ex_pc), .i_rs1(ex_rs1), .i_imm(ex_imm), .o_taken(br_taken), .o_target(br_target)
  );

  ex_result_reg #(.XLEN(XLEN)) u_result_reg (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(ex_valid), .i_rd_addr(ex_rd_addr),
    .i_rd_we(ex_rd_we), .i_result(alu_result), .i_taken(br_taken), .i_target(br_target),
    .o_valid(o_valid), .o_rd_addr(o_rd_addr), .o_rd_we(o_rd_we), .o_rd_data(o_rd_data),
    .o_redirect(o_redirect), .o_target(o_target)
  );

endmodule

`default_nettype wire

//--- source/ex_result_reg.sv
/* second execute pipeline register: writeback value and redirect outputs */
`timescale 1ns/100ps
`default_nettype none

module ex_result_reg #(
  parameter int XLEN = 32
) (
  input  wire logic            i_clk,
  input  wire logic            i_rst,
  input  wire logic            i_valid,
  input  wire logic [4:0]      i_rd_addr,
  input  wire logic            i_rd_we,
  input  wire logic [XLEN-1:0] i_result,
  input  wire logic            i_taken,
  input  wire logic [XLEN-1:0] i_target,
  output logic                 o_valid,
  output logic      [4:0]      o_rd_addr,
  output logic                 o_rd_we,
  output logic      [XLEN-1:0] o_rd_data,
  output logic                 o_redirect,
  output logic      [XLEN-1:0] o_target
);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid    <= 1'b0;
      o_rd_we    <= 1'b0;
      o_redirect <= 1'b0;
    end else begin
      o_valid    <= i_valid;
      o_rd_we    <= i_valid & i_rd_we;  // a bubble never writes
      o_redirect <= i_valid & i_taken;
    end
  end

  always_ff @(posedge i_clk) begin
    o_rd_addr <= i_rd_addr;
    o_rd_data <= i_result;
    o_target  <= i_target;
  end

endmodule

`default_nettype wire

//--- source/branch_unit.sv
/* branch resolution from the ALU flags and branch/jump target address */
`timescale 1ns/100ps
`default_nettype none

module branch_unit import rv_isa_pkg::*; #(
  parameter int XLEN = 32
) (
  input  wire logic            i_is_branch,
  input  wire logic            i_is_jal,
  input  wire logic            i_is_jalr,
  input  br_funct3_t           i_funct3,
  input  wire logic            i_zflag,
  input  wire logic            i_cflag,
  input  wire logic            i_lflag,
  input  wire logic [XLEN-1:0] i_pc,
  input  wire logic [XLEN-1:0] i_rs1,
  input  wire logic [XLEN-1:0] i_imm,
  output logic                 o_taken,
  output logic      [XLEN-1:0] o_target
);

  logic            cond;
  logic [XLEN-1:0] base;
  logic [XLEN-1:0] sum;

  always_comb begin
    case (i_funct3)
      BEQ:     cond = i_zflag;
      BNE:     cond = ~i_zflag;
      BLT:     cond = i_lflag;
      BGE:     cond = ~i_lflag;
      BLTU:    cond = ~i_cflag;  // borrow out means A < B unsigned
      BGEU:    cond = i_cflag;
      default: cond = 1'b0;     // reserved encodings never branch
    endcase
  end

  assign o_taken = i_is_jal | i_is_jalr | (i_is_branch & cond);

  assign base = i_is_jalr ? i_rs1 : i_pc;
  assign sum  = base + i_imm;

  // JALR drops bit 0 of the computed address
  assign o_target = i_is_jalr ? {sum[XLEN-1:1], 1'b0} : sum;

endmodule

`default_nettype wire

//--- source/alu.sv
/* integer ALU with a shared add/subtract path and zero, carry, less-than flags */
`timescale 1ns/100ps
`default_nettype none

module alu import alu_pkg::*; #(
  parameter int XLEN = 32
) (
  input  wire logic [XLEN-1:0] i_a,
  input  wire logic [XLEN-1:0] i_b,
  input  alu_op_t              i_op,
  output logic      [XLEN-1:0] o_result,
  output logic                 o_zflag,
  output logic                 o_cflag,
  output logic                 o_lflag
);

  localparam int SHW = $clog2(XLEN);  // shift amount width

  logic [XLEN-1:0] b_in;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] xor_res;
  logic [SHW-1:0]  shamt;
  logic            sub;
  logic            carry;  // set when A >= B unsigned on a subtract
  logic            slt;

  assign xor_res = i_a ^ i_b;
  assign shamt   = i_b[SHW-1:0];

  always_comb begin
    case (i_op)
      ALU_SUB, ALU_SLT, ALU_SLTU, ALU_SGTE, ALU_SGTEU: begin
        b_in = ~i_b;
        sub  = 1'b1;
      end
      ALU_ADD4A: begin
        b_in = XLEN'(4);
        sub  = 1'b0;
      end
      default: begin
        b_in = i_b;
        sub  = 1'b0;
      end
    endcase
  end

  // the single adder, carry-in completes the two's complement of B
  assign {carry, sum} = {1'b0, i_a} + {1'b0, b_in} + {{XLEN{1'b0}}, sub};

  // signs equal means no overflow, so the difference sign is the answer
  assign slt = (i_a[XLEN-1] ~^ i_b[XLEN-1]) ? sum[XLEN-1] : i_a[XLEN-1];

  always_comb begin
    case (i_op)
      ALU_AND:   o_result = i_a & i_b;
      ALU_OR:    o_result = i_a | i_b;
      ALU_XOR:   o_result = xor_res;
      ALU_SLL:   o_result = i_a << shamt;
      ALU_SRL:   o_result = i_a >> shamt;
      ALU_SRA:   o_result = $signed(i_a) >>> shamt;
      ALU_PASSB: o_result = i_b;
      ALU_SLT:   o_result = {{(XLEN-1){1'b0}}, slt};
      ALU_SLTU:  o_result = {{(XLEN-1){1'b0}}, ~carry};
      ALU_SGTE:  o_result = {{(XLEN-1){1'b0}}, ~slt};
      ALU_SGTEU: o_result = {{(XLEN-1){1'b0}}, carry};
      default:   o_result = sum;  // ADD, SUB, ADD4A
    endcase
  end

  assign o_zflag = ~|xor_res;
  assign o_cflag = carry;
  assign o_lflag = slt;

endmodule

`default_nettype wire

//--- source/ex_operand_reg.sv
/* first execute pipeline register: operand A/B selection and decoded fields */
`timescale 1ns/100ps
`default_nettype none

module ex_operand_reg import alu_pkg::*; #(
  parameter int XLEN = 32
) (
  input  wire logic            i_clk,
  input  wire logic            i_rst,
  input  wire logic            i_valid,
  input  wire logic [XLEN-1:0] i_pc,
  input  wire logic [XLEN-1:0] i_rs1_data,
  input  wire logic [XLEN-1:0] i_rs2_data,
  input  alu_op_t              i_alu_op,
  input  a_sel_t               i_a_sel,
  input  b_sel_t               i_b_sel,
  input  wire logic [XLEN-1:0] i_imm,
  input  wire logic [4:0]      i_rd_addr,
  input  wire logic            i_rd_we,
  input  wire logic            i_is_branch,
  input  wire logic            i_is_jal,
  input  wire logic            i_is_jalr,
  input  wire logic [2:0]      i_funct3,
  output logic                 o_valid,
  output logic      [XLEN-1:0] o_a,
  output logic      [XLEN-1:0] o_b,
  output alu_op_t              o_alu_op,
  output logic      [XLEN-1:0] o_pc,
  output logic      [XLEN-1:0] o_rs1,
  output logic      [XLEN-1:0] o_imm,
  output logic      [4:0]      o_rd_addr,
  output logic                 o_rd_we,
  output logic                 o_is_branch,
  output logic                 o_is_jal,
  output logic                 o_is_jalr,
  output logic      [2:0]      o_funct3
);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  // payload loads every cycle, bubbles are masked downstream by valid
  always_ff @(posedge i_clk) begin
    o_a         <= (i_a_sel == SEL_PC) ? i_pc : i_rs1_data;
    o_b         <= (i_b_sel == SEL_IMM) ? i_imm : i_rs2_data;
    o_alu_op    <= i_alu_op;
    o_pc        <= i_pc;
    o_rs1       <= i_rs1_data;  // JALR target base
    o_imm       <= i_imm;
    o_rd_addr   <= i_rd_addr;
    o_rd_we     <= i_rd_we;
    o_is_branch <= i_is_branch;
    o_is_jal    <= i_is_jal;
    o_is_jalr   <= i_is_jalr;
    o_funct3    <= i_funct3;
  end

endmodule

`default_nettype wire

//--- source/instr_decoder.sv
/* combinational instruction decoder: ALU op, operand selects, immediate,
   branch and jump class, rd address and write enable */
`timescale 1ns/100ps
`default_nettype none

module instr_decoder import rv_isa_pkg::*, alu_pkg::*; #(
  parameter int XLEN = 32
) (
  input  wire logic [INSTR_W-1:0]    i_instr,
  output alu_op_t                    o_alu_op,
  output a_sel_t                     o_a_sel,
  output b_sel_t                     o_b_sel,
  output logic      [XLEN-1:0]       o_imm,
  output logic      [REG_ADDR_W-1:0] o_rd_addr,
  output logic                       o_rd_we,
  output logic                       o_is_branch,
  output logic                       o_is_jal,
  output logic                       o_is_jalr,
  output logic      [2:0]            o_funct3
);

  opcode_t         opcode;
  logic [2:0]      funct3;
  logic            f7b5;
  logic [XLEN-1:0] imm_i, imm_u, imm_b, imm_j;
  logic            we;

  assign opcode = opcode_t'(i_instr[6:0]);
  assign funct3 = i_instr[FUNCT3_LSB +: 3];
  assign f7b5   = i_instr[FUNCT7_B5];

  // sign-extended immediates for each encoding format
  assign imm_i = XLEN'($signed(i_instr[31:20]));
  assign imm_u = XLEN'($signed({i_instr[31:12], 12'b0}));
  assign imm_b = XLEN'($signed({i_instr[31], i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0}));
  assign imm_j = XLEN'($signed({i_instr[31], i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0}));

  always_comb begin
    o_alu_op    = ALU_ADD;
    o_a_sel     = SEL_RS1;
    o_b_sel     = SEL_RS2;
    o_imm       = imm_i;
    we          = 1'b0;
    o_is_branch = 1'b0;
    o_is_jal    = 1'b0;
    o_is_jalr   = 1'b0;
    case (opcode)
      OP, OP_IMM: begin
        we      = 1'b1;
        o_b_sel = (opcode == OP_IMM) ? SEL_IMM : SEL_RS2;
        case (funct3)
          3'b000:  o_alu_op = (opcode == OP && f7b5) ? ALU_SUB : ALU_ADD;  // no SUBI
          3'b001:  o_alu_op = ALU_SLL;
          3'b010:  o_alu_op = ALU_SLT;
          3'b011:  o_alu_op = ALU_SLTU;
          3'b100:  o_alu_op = ALU_XOR;
          3'b101:  o_alu_op = f7b5 ? ALU_SRA : ALU_SRL;
          3'b110:  o_alu_op = ALU_OR;
          default: o_alu_op = ALU_AND;
        endcase
      end
      LUI: begin
        we       = 1'b1;
        o_b_sel  = SEL_IMM;
        o_imm    = imm_u;
        o_alu_op = ALU_PASSB;
      end
      AUIPC: begin
        we       = 1'b1;
        o_a_sel  = SEL_PC;
        o_b_sel  = SEL_IMM;
        o_imm    = imm_u;
      end
      JAL: begin
        we       = 1'b1;
        o_is_jal = 1'b1;
        o_a_sel  = SEL_PC;
        o_imm    = imm_j;
        o_alu_op = ALU_ADD4A;  // link value, target comes from the branch unit
      end
      JALR: begin
        we        = 1'b1;
        o_is_jalr = 1'b1;
        o_a_sel   = SEL_PC;
        o_alu_op  = ALU_ADD4A;
      end
      BRANCH: begin
        o_is_branch = 1'b1;
        o_imm       = imm_b;
        case (br_funct3_t'(funct3))
          BLT:     o_alu_op = ALU_SLT;
          BGE:     o_alu_op = ALU_SGTE;
          BLTU:    o_alu_op = ALU_SLTU;
          BGEU:    o_alu_op = ALU_SGTEU;
          default: o_alu_op = ALU_SUB;  // BEQ and BNE only look at the zero flag
        endcase
      end
      default: ;  // unsupported opcode, nothing is written
    endcase
  end

  assign o_rd_addr = i_instr[RD_LSB +: REG_ADDR_W];
  assign o_rd_we   = we && (o_rd_addr != '0);  // x0 is never written
  assign o_funct3  = funct3;

endmodule

`default_nettype wire

//--- source/alu_pkg.sv
/* ALU operation codes and the operand-select codes for A and B */
`default_nettype none

package alu_pkg;

  localparam int ALU_OP_W = 5;  // width of the operation code

  typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_SGTE,
    ALU_SGTEU,
    ALU_PASSB,  // result is operand B unchanged
    ALU_ADD4A   // operand A plus 4, the link address
  } alu_op_t;

  // operand A source
  typedef enum logic {
    SEL_RS1 = 1'b0,
    SEL_PC  = 1'b1
  } a_sel_t;

  // operand B source
  typedef enum logic {
    SEL_RS2 = 1'b0,
    SEL_IMM = 1'b1
  } b_sel_t;

endpackage

`default_nettype wire

//--- source/rv_isa_pkg.sv
/* RV32I instruction encodings: opcode and branch funct3 enums,
   instruction width and register field positions */
`default_nettype none

package rv_isa_pkg;

  localparam int INSTR_W = 32;  // width of one raw instruction

  // major opcodes handled by the execute stage
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011
  } opcode_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } br_funct3_t;

  localparam int REG_ADDR_W = 5;   // register index width
  localparam int RD_LSB     = 7;   // rd field starts here
  localparam int FUNCT3_LSB = 12;  // 3-bit funct3 field
  localparam int RS1_LSB    = 15;  // rs1 field
  localparam int RS2_LSB    = 20;  // rs2 field, also shamt for immediate shifts
  localparam int FUNCT7_B5  = 30;  // selects SUB and SRA

endpackage

`default_nettype wire
